// File: bench/axi_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_checker
  import axi_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          i_aw_valid,
  input  wire axi_addr_req_t i_aw,
  input  wire logic          o_aw_ready,
  input  wire logic          i_w_valid,
  input  wire axi_w_beat_t   i_w,
  input  wire logic          o_w_ready,
  input  wire logic          o_b_valid,
  input  wire axi_b_chan_t   o_b,
  input  wire logic          i_b_ready,
  input  wire logic          i_ar_valid,
  input  wire axi_addr_req_t i_ar,
  input  wire logic          o_ar_ready,
  input  wire logic          o_r_valid,
  input  wire axi_r_chan_t   o_r,
  input  wire logic          i_r_ready,
  output int                 o_errors
);

  localparam logic [ADDR_W-1:0] LANE_MASK = ADDR_W'(STRB_W - 1);

  // Byte model filled only from observed write beats
  logic [7:0]        model [256];
  bit                known [256];
  axi_addr_req_t     wr_req;
  logic [ADDR_W-1:0] wr_addr;
  axi_addr_req_t     rd_req;
  logic [ADDR_W-1:0] rd_addr;
  int                rd_beat = 0;
  bit                rd_open = 0;
  bit                b_hold = 0;
  bit                r_hold = 0;
  axi_b_chan_t       b_prev;
  axi_r_chan_t       r_prev;
  int                errors = 0;

  assign o_errors = errors;

  function automatic logic [ADDR_W-1:0] beat_step(input logic [ADDR_W-1:0] addr,
                                                  input logic [2:0] size,
                                                  input logic [1:0] burst);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + (ADDR_W'(1) << size);
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    logic [ADDR_W-1:0] byte_addr;
    logic [DATA_W-1:0] exp_word;
    logic [DATA_W-1:0] mask;

    if (!rst_n) begin
      b_hold  = 0;
      r_hold  = 0;
      rd_open = 0;
    end else begin
      // ----------------------------------------
      // Stall stability
      // ----------------------------------------
      if (b_hold) begin
        check_val("b_valid", 64'(1'b1), 64'(o_b_valid));
        check_val("b payload", 64'(b_prev), 64'(o_b));
      end
      if (r_hold) begin
        check_val("r_valid", 64'(1'b1), 64'(o_r_valid));
        check_val("r payload", 64'(r_prev), 64'(o_r));
      end

      // ----------------------------------------
      // Write side
      // ----------------------------------------
      if (i_aw_valid && o_aw_ready) begin
        wr_req  = i_aw;
        wr_addr = i_aw.addr;
      end
      if (i_w_valid && o_w_ready) begin
        for (int i = 0; i < STRB_W; i++) begin
          byte_addr = (wr_addr & ~LANE_MASK) | ADDR_W'(i);
          if (i_w.strb[i]) begin
            model[byte_addr] = i_w.data[8*i +: 8];
            known[byte_addr] = 1;
          end
        end
        wr_addr = beat_step(wr_addr, wr_req.size, wr_req.burst);
      end
      if (o_b_valid && i_b_ready) begin
        check_val("bid", 64'(wr_req.id), 64'(o_b.id));
        check_val("bresp", 64'(RESP_OKAY), 64'(o_b.resp));
      end

      // ----------------------------------------
      // Read side
      // ----------------------------------------
      if (o_r_valid && i_r_ready) begin
        if (!rd_open) begin
          $display("Read beat at time %0t arrived with no read burst open", $time);
          errors++;
        end else begin
          for (int i = 0; i < STRB_W; i++) begin
            byte_addr = (rd_addr & ~LANE_MASK) | ADDR_W'(i);
            exp_word[8*i +: 8] = model[byte_addr];
            mask[8*i +: 8]     = known[byte_addr] ? 8'hFF : 8'h00;
          end
          // Bytes never written are left out of the compare
          check_val("rdata", 64'(exp_word & mask), 64'(o_r.data & mask));
          check_val("rid", 64'(rd_req.id), 64'(o_r.id));
          check_val("rlast", 64'(rd_beat == int'(rd_req.len)), 64'(o_r.last));
          check_val("rresp", 64'(RESP_OKAY), 64'(o_r.resp));
          rd_addr = beat_step(rd_addr, rd_req.size, rd_req.burst);
          rd_beat++;
          if (rd_beat > int'(rd_req.len)) begin
            rd_open = 0;
          end
        end
      end
      if (i_ar_valid && o_ar_ready) begin
        rd_req  = i_ar;
        rd_addr = i_ar.addr;
        rd_beat = 0;
        rd_open = 1;
      end

      b_hold = o_b_valid && !i_b_ready;
      b_prev = o_b;
      r_hold = o_r_valid && !i_r_ready;
      r_prev = o_r;
    end
  end

endmodule

`default_nettype wire

// File: bench/axi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_tb
  import axi_pkg::*;
;

  localparam int TIMEOUT = 200;
  localparam int SEED    = 44989;

  typedef struct {
    bit         is_write;
    bit         par;
    logic [3:0] id;
    logic [7:0] addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] strb;
    int         stall;
  } txn_t;

  logic          clk;
  logic          rst_n;
  logic          i_aw_valid;
  axi_addr_req_t i_aw;
  logic          o_aw_ready;
  logic          i_w_valid;
  axi_w_beat_t   i_w;
  logic          o_w_ready;
  logic          o_b_valid;
  axi_b_chan_t   o_b;
  logic          i_b_ready;
  logic          i_ar_valid;
  axi_addr_req_t i_ar;
  logic          o_ar_ready;
  logic          o_r_valid;
  axi_r_chan_t   o_r;
  logic          i_r_ready;

  txn_t rows [$];
  int   chk_errors;
  int   drv_errors = 0;
  bit   aborted = 0;

  axi_mem_top axi_mem_top_inst (.*);

  axi_mem_checker checker_inst (.*, .o_errors(chk_errors));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic add_row(input bit is_write, input bit par, input logic [3:0] id,
                         input logic [7:0] addr, input logic [7:0] len, input logic [2:0] size,
                         input logic [1:0] burst, input logic [3:0] strb, input int stall);
    rows.push_back('{is_write, par, id, addr, len, size, burst, strb, stall});
  endtask

  function automatic logic pick_ready(input int stall_pct);
    return ($urandom % 100) >= 32'(stall_pct);
  endfunction

  task automatic expect_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %0b actual %0b", $time, name, exp, act);
      drv_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    drv_errors++;
    aborted = 1;
  endtask

  // ----------------------------------------
  // Burst drivers enter and leave on a falling edge
  // ----------------------------------------
  task automatic run_write(input txn_t t);
    axi_w_beat_t beat;
    logic [7:0]  lane_addr;
    int          n;

    i_aw       = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    i_aw_valid = 1'b1;
    n = 0;
    while (!o_aw_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_aw_ready) begin
      report_timeout("aw_ready");
      i_aw_valid = 1'b0;
      return;
    end
    @(negedge clk);
    i_aw_valid = 1'b0;

    for (int b = 0; b <= int'(t.len); b++) begin
      lane_addr = t.addr + 8'(b);
      beat.data = $urandom;
      // Byte bursts enable only the lane under the current address
      beat.strb = (t.size == 3'd0) ? (4'b0001 << lane_addr[1:0]) : t.strb;
      beat.last = (b == int'(t.len));
      i_w       = beat;
      i_w_valid = 1'b1;
      n = 0;
      while (!o_w_ready && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!o_w_ready) begin
        report_timeout("w_ready");
        i_w_valid = 1'b0;
        return;
      end
      @(negedge clk);
    end
    i_w_valid = 1'b0;

    n = 0;
    i_b_ready = pick_ready(t.stall);
    while (!(o_b_valid && i_b_ready) && n < TIMEOUT) begin
      @(negedge clk);
      i_b_ready = pick_ready(t.stall);
      n++;
    end
    if (!(o_b_valid && i_b_ready)) begin
      report_timeout("b_valid");
      i_b_ready = 1'b0;
      return;
    end
    @(negedge clk);
    i_b_ready = 1'b0;
  endtask

  task automatic run_read(input txn_t t);
    int n;
    int beats;

    i_ar       = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    i_ar_valid = 1'b1;
    n = 0;
    while (!o_ar_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_ar_ready) begin
      report_timeout("ar_ready");
      i_ar_valid = 1'b0;
      return;
    end
    @(negedge clk);
    i_ar_valid = 1'b0;

    beats = 0;
    while (beats <= int'(t.len)) begin
      n = 0;
      i_r_ready = pick_ready(t.stall);
      while (!(o_r_valid && i_r_ready) && n < TIMEOUT) begin
        @(negedge clk);
        i_r_ready = pick_ready(t.stall);
        n++;
      end
      if (!(o_r_valid && i_r_ready)) begin
        report_timeout("r_valid");
        i_r_ready = 1'b0;
        return;
      end
      @(negedge clk);
      beats++;
    end
    i_r_ready = 1'b0;
  endtask

  task automatic run_row(input txn_t t);
    if (t.is_write) begin
      run_write(t);
    end else begin
      run_read(t);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int i;

    void'($urandom(SEED));
    rst_n      = 1'b0;
    i_aw_valid = 1'b0;
    i_aw       = '0;
    i_w_valid  = 1'b0;
    i_w        = '0;
    i_b_ready  = 1'b0;
    i_ar_valid = 1'b0;
    i_ar       = '0;
    i_r_ready  = 1'b0;

    //      wr  par id     addr   len    size  burst        strb     stall
    add_row(1, 0, 4'h1, 8'h00, 8'd7,  3'd2, BURST_INCR,  4'b1111, 0);
    add_row(0, 0, 4'h2, 8'h00, 8'd7,  3'd2, BURST_INCR,  4'b1111, 0);
    add_row(1, 0, 4'h3, 8'h04, 8'd1,  3'd2, BURST_INCR,  4'b0101, 0);
    add_row(0, 0, 4'h4, 8'h00, 8'd3,  3'd2, BURST_INCR,  4'b1111, 0);
    add_row(1, 0, 4'h5, 8'h40, 8'd0,  3'd2, BURST_INCR,  4'b1111, 0);
    add_row(1, 0, 4'h6, 8'h40, 8'd3,  3'd2, BURST_FIXED, 4'b0110, 0);
    add_row(0, 0, 4'h7, 8'h40, 8'd4,  3'd2, BURST_FIXED, 4'b1111, 0);
    add_row(1, 0, 4'h8, 8'h80, 8'd7,  3'd0, BURST_INCR,  4'b0001, 30);
    add_row(0, 0, 4'h9, 8'h80, 8'd7,  3'd0, BURST_INCR,  4'b1111, 30);
    add_row(1, 1, 4'hA, 8'hC0, 8'd15, 3'd2, BURST_INCR,  4'b1111, 40);
    add_row(0, 0, 4'hB, 8'h00, 8'd7,  3'd2, BURST_INCR,  4'b1111, 40);
    add_row(0, 0, 4'hC, 8'hC0, 8'd15, 3'd2, BURST_INCR,  4'b1111, 50);
    add_row(1, 1, 4'hD, 8'h20, 8'd3,  3'd2, BURST_INCR,  4'b1111, 50);
    add_row(0, 0, 4'hE, 8'h80, 8'd0,  3'd2, BURST_INCR,  4'b1111, 50);
    add_row(0, 0, 4'hF, 8'h20, 8'd3,  3'd2, BURST_INCR,  4'b1111, 30);

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    expect_level("aw_ready", 1'b1, o_aw_ready);
    expect_level("ar_ready", 1'b1, o_ar_ready);
    expect_level("w_ready", 1'b0, o_w_ready);
    expect_level("b_valid", 1'b0, o_b_valid);
    expect_level("r_valid", 1'b0, o_r_valid);

    // Rows marked par run together with the row after them
    i = 0;
    while (i < rows.size() && !aborted) begin
      if (rows[i].par && i + 1 < rows.size()) begin
        fork
          run_row(rows[i]);
          run_row(rows[i + 1]);
        join
        i += 2;
      end else begin
        run_row(rows[i]);
        i++;
      end
    end

    repeat (4) @(negedge clk);
    $display("Errors: checker %0d, driver %0d", chk_errors, drv_errors);
    if (chk_errors == 0 && drv_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/axi_burst_addr.sv
rtl/axi_mem_ram.sv
rtl/axi_resp_slot.sv
rtl/axi_mem_ctrl.sv
rtl/axi_mem_top.sv
bench/axi_mem_checker.sv
bench/axi_mem_tb.sv

// File: rtl/axi_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr
  import axi_pkg::*, mem_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          i_load,
  input  wire logic          i_step,
  input  wire axi_addr_req_t i_req,
  output logic [MEM_AW-1:0]  o_word_addr
);

  logic [ADDR_W-1:0] addr_q;
  logic [2:0]        size_q;
  logic [1:0]        burst_q;

  // Incoming request takes over on load, so its first beat needs no wait
  logic [ADDR_W-1:0] cur_addr;
  logic [2:0]        cur_size;
  logic [1:0]        cur_burst;
  logic [ADDR_W-1:0] next_addr;

  assign cur_addr  = i_load ? i_req.addr  : addr_q;
  assign cur_size  = i_load ? i_req.size  : size_q;
  assign cur_burst = i_load ? i_req.burst : burst_q;

  // WRAP steps like INCR, FIXED holds
  always_comb begin
    next_addr = cur_addr;
    if (i_step && (cur_burst == BURST_INCR || cur_burst == BURST_WRAP)) begin
      next_addr = cur_addr + (ADDR_W'(1) << cur_size);
    end
  end

  assign o_word_addr = cur_addr[ADDR_W-1:WORD_LSB];

  always_ff @(posedge clk) begin
    addr_q  <= next_addr;
    size_q  <= cur_size;
    burst_q <= cur_burst;
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_ctrl
  import axi_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,

  input  wire logic          i_aw_valid,
  input  wire axi_addr_req_t i_aw,
  output logic               o_aw_ready,
  input  wire logic          i_w_valid,
  input  wire logic          i_w_last,
  output logic               o_w_ready,
  input  wire logic          i_ar_valid,
  input  wire axi_addr_req_t i_ar,
  output logic               o_ar_ready,

  output logic               o_wa_load,
  output logic               o_wa_step,
  output logic               o_ra_load,
  output logic               o_ra_step,
  output logic               o_mem_wr_en,
  output logic               o_mem_rd_en,

  output logic               o_b_load,
  output axi_b_meta_t        o_b_meta,
  input  wire logic          i_b_valid,
  input  wire logic          i_b_ready,
  output logic               o_r_load,
  output axi_r_meta_t        o_r_meta,
  input  wire logic          i_r_valid,
  input  wire logic          i_r_ready
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_BURST,
    W_RESP
  } w_state_t;

  typedef enum logic {
    R_IDLE,
    R_BURST
  } r_state_t;

  w_state_t        w_state;
  w_state_t        w_state_next;
  logic            aw_ready_next;
  logic            w_ready_next;
  logic [ID_W-1:0] w_id;
  logic            b_free;

  r_state_t        r_state;
  r_state_t        r_state_next;
  logic            ar_ready_next;
  logic [ID_W-1:0] r_id;
  // Beats still to issue after the one going out now
  logic [7:0]      r_left;
  logic [7:0]      r_left_next;
  logic            r_free;

  // A slot can take a new entry when empty or draining this edge
  assign b_free = !i_b_valid || i_b_ready;
  assign r_free = !i_r_valid || i_r_ready;

  // ----------------------------------------
  // Write side
  // ----------------------------------------
  always_comb begin
    w_state_next  = w_state;
    aw_ready_next = o_aw_ready;
    w_ready_next  = o_w_ready;
    o_wa_load     = 1'b0;
    o_mem_wr_en   = 1'b0;
    o_b_load      = 1'b0;

    case (w_state)
      W_IDLE: begin
        if (i_aw_valid && o_aw_ready) begin
          o_wa_load     = 1'b1;
          aw_ready_next = 1'b0;
          w_ready_next  = 1'b1;
          w_state_next  = W_BURST;
        end
      end
      W_BURST: begin
        if (i_w_valid && o_w_ready) begin
          o_mem_wr_en = 1'b1;
          // Burst ends on wlast, awlen is not checked
          if (i_w_last) begin
            w_ready_next = 1'b0;
            if (b_free) begin
              o_b_load      = 1'b1;
              aw_ready_next = 1'b1;
              w_state_next  = W_IDLE;
            end else begin
              w_state_next = W_RESP;
            end
          end
        end
      end
      W_RESP: begin
        if (b_free) begin
          o_b_load      = 1'b1;
          aw_ready_next = 1'b1;
          w_state_next  = W_IDLE;
        end
      end
      default: w_state_next = W_IDLE;
    endcase
  end

  assign o_wa_step = o_mem_wr_en;
  assign o_b_meta  = '{id: w_id};

  // ----------------------------------------
  // Read side
  // ----------------------------------------
  always_comb begin
    r_state_next  = r_state;
    ar_ready_next = o_ar_ready;
    r_left_next   = r_left;
    o_ra_load     = 1'b0;
    o_mem_rd_en   = 1'b0;
    o_r_meta      = '{id: r_id, last: (r_left == 8'd0)};

    case (r_state)
      R_IDLE: begin
        if (i_ar_valid && o_ar_ready) begin
          o_ra_load     = 1'b1;
          ar_ready_next = 1'b0;
          r_state_next  = R_BURST;
          r_left_next   = i_ar.len;
          o_r_meta      = '{id: i_ar.id, last: (i_ar.len == 8'd0)};
          // First beat goes out with the request when the slot allows
          if (r_free) begin
            o_mem_rd_en = 1'b1;
            r_left_next = i_ar.len - 8'd1;
            if (i_ar.len == 8'd0) begin
              r_state_next  = R_IDLE;
              ar_ready_next = 1'b1;
            end
          end
        end
      end
      R_BURST: begin
        if (r_free) begin
          o_mem_rd_en = 1'b1;
          r_left_next = r_left - 8'd1;
          if (r_left == 8'd0) begin
            r_state_next  = R_IDLE;
            ar_ready_next = 1'b1;
          end
        end
      end
      default: r_state_next = R_IDLE;
    endcase
  end

  // RAM read and R metadata move as one
  assign o_ra_step = o_mem_rd_en;
  assign o_r_load  = o_mem_rd_en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_state    <= W_IDLE;
      o_aw_ready <= 1'b1;
      o_w_ready  <= 1'b0;
      r_state    <= R_IDLE;
      o_ar_ready <= 1'b1;
      r_left     <= 8'd0;
    end else begin
      w_state    <= w_state_next;
      o_aw_ready <= aw_ready_next;
      o_w_ready  <= w_ready_next;
      r_state    <= r_state_next;
      o_ar_ready <= ar_ready_next;
      r_left     <= r_left_next;
    end
  end

  always_ff @(posedge clk) begin
    if (o_wa_load) begin
      w_id <= i_aw.id;
    end
    if (o_ra_load) begin
      r_id <= i_ar.id;
    end
  end

  // Address and data phases of a write never overlap
  assert property (@(posedge clk) disable iff (!rst_n) !(o_aw_ready && o_w_ready));

  // Every read-address step leaves its beat waiting in the R slot
  assert property (@(posedge clk) disable iff (!rst_n) o_ra_step |=> i_r_valid);

endmodule

`default_nettype wire

// File: rtl/axi_mem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_ram
  import axi_pkg::*, mem_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              i_wr_en,
  input  wire logic [MEM_AW-1:0] i_wr_addr,
  input  wire logic [DATA_W-1:0] i_wr_data,
  input  wire logic [STRB_W-1:0] i_wr_strb,
  input  wire logic              i_rd_en,
  input  wire logic [MEM_AW-1:0] i_rd_addr,
  output logic      [DATA_W-1:0] o_rd_data
);

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  // One enable per byte lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_W; i++) begin
      if (i_wr_en && i_wr_strb[i]) begin
        mem[i_wr_addr][8*i +: 8] <= i_wr_data[8*i +: 8];
      end
    end
  end

  // Holds between reads so R data stays put while the host stalls
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top
  import axi_pkg::*, mem_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,

  input  wire logic          i_aw_valid,
  input  wire axi_addr_req_t i_aw,
  output logic               o_aw_ready,
  input  wire logic          i_w_valid,
  input  wire axi_w_beat_t   i_w,
  output logic               o_w_ready,
  output logic               o_b_valid,
  output axi_b_chan_t        o_b,
  input  wire logic          i_b_ready,

  input  wire logic          i_ar_valid,
  input  wire axi_addr_req_t i_ar,
  output logic               o_ar_ready,
  output logic               o_r_valid,
  output axi_r_chan_t        o_r,
  input  wire logic          i_r_ready
);

  logic              wa_load;
  logic              wa_step;
  logic              ra_load;
  logic              ra_step;
  logic              mem_wr_en;
  logic              mem_rd_en;
  logic [MEM_AW-1:0] wr_word_addr;
  logic [MEM_AW-1:0] rd_word_addr;
  logic [DATA_W-1:0] rd_data;

  logic              b_load;
  axi_b_meta_t       b_meta;
  axi_b_meta_t       b_meta_q;
  logic              r_load;
  axi_r_meta_t       r_meta;
  axi_r_meta_t       r_meta_q;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  axi_mem_ctrl axi_mem_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_aw_valid  (i_aw_valid),
    .i_aw        (i_aw),
    .o_aw_ready  (o_aw_ready),
    .i_w_valid   (i_w_valid),
    .i_w_last    (i_w.last),
    .o_w_ready   (o_w_ready),
    .i_ar_valid  (i_ar_valid),
    .i_ar        (i_ar),
    .o_ar_ready  (o_ar_ready),
    .o_wa_load   (wa_load),
    .o_wa_step   (wa_step),
    .o_ra_load   (ra_load),
    .o_ra_step   (ra_step),
    .o_mem_wr_en (mem_wr_en),
    .o_mem_rd_en (mem_rd_en),
    .o_b_load    (b_load),
    .o_b_meta    (b_meta),
    .i_b_valid   (o_b_valid),
    .i_b_ready   (i_b_ready),
    .o_r_load    (r_load),
    .o_r_meta    (r_meta),
    .i_r_valid   (o_r_valid),
    .i_r_ready   (i_r_ready)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  axi_burst_addr wr_addr_inst (
    .clk         (clk),
    .i_load      (wa_load),
    .i_step      (wa_step),
    .i_req       (i_aw),
    .o_word_addr (wr_word_addr)
  );

  axi_burst_addr rd_addr_inst (
    .clk         (clk),
    .i_load      (ra_load),
    .i_step      (ra_step),
    .i_req       (i_ar),
    .o_word_addr (rd_word_addr)
  );

  axi_mem_ram axi_mem_ram_inst (
    .clk       (clk),
    .i_wr_en   (mem_wr_en),
    .i_wr_addr (wr_word_addr),
    .i_wr_data (i_w.data),
    .i_wr_strb (i_w.strb),
    .i_rd_en   (mem_rd_en),
    .i_rd_addr (rd_word_addr),
    .o_rd_data (rd_data)
  );

  axi_resp_slot #(.payload_t(axi_b_meta_t)) b_slot_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_load    (b_load),
    .i_payload (b_meta),
    .i_ready   (i_b_ready),
    .o_valid   (o_b_valid),
    .o_payload (b_meta_q)
  );

  axi_resp_slot #(.payload_t(axi_r_meta_t)) r_slot_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_load    (r_load),
    .i_payload (r_meta),
    .i_ready   (i_r_ready),
    .o_valid   (o_r_valid),
    .o_payload (r_meta_q)
  );

  // RAM data lines up with the R slot contents
  assign o_b = '{id: b_meta_q.id, resp: RESP_OKAY};
  assign o_r = '{id: r_meta_q.id, data: rd_data, resp: RESP_OKAY, last: r_meta_q.last};

endmodule

`default_nettype wire

// File: rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // Burst type codes
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // Only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------

  // Shared by AW and AR
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_addr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_beat_t;

  // What the response slots hold, before the fixed fields are added
  typedef struct packed {
    logic [ID_W-1:0] id;
  } axi_b_meta_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            last;
  } axi_r_meta_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_chan_t;

endpackage

`default_nettype wire

// File: rtl/axi_resp_slot.sv
`timescale 1ns/1ps
`default_nettype none

module axi_resp_slot #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     i_load,
  input  wire payload_t i_payload,
  input  wire logic     i_ready,
  output logic          o_valid,
  output payload_t      o_payload
);

  // A load wins over a transfer at the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else if (i_load) begin
      o_valid <= 1'b1;
    end else if (o_valid && i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      o_payload <= i_payload;
    end
  end

  // A stalled response keeps valid and payload
  assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_payload));

  // The producer only loads into a free slot
  assert property (@(posedge clk) disable iff (!rst_n)
    i_load |-> !o_valid || i_ready);

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // ----------------------------------------
  // Memory geometry
  // ----------------------------------------

  // Byte offset inside one data word
  localparam int WORD_LSB = $clog2(axi_pkg::STRB_W);

  // Word address width with the byte offset dropped
  localparam int MEM_AW = axi_pkg::ADDR_W - WORD_LSB;

  // Whole address space is backed
  localparam int MEM_DEPTH = 1 << MEM_AW;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f project.f --top-module axi_mem_tb -o axi_mem_sim \
  && ./obj_dir/axi_mem_sim | grep "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
